//--- compile.f
+incdir+logic
logic/pfa_pkg.sv
logic/sig_delay.sv
logic/twdl_ctrl.sv
logic/twdl_rom.sv
logic/cmul_lane.sv
logic/twdl_stage.sv
test/clk_gen.sv
test/twdl_chk.sv
test/twdl_tb.sv

//--- logic/cmul_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "pfa_params.svh"

module cmul_lane
	import pfa_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,

	input  logic     lane_val,
	input  sample_t  din_real,
	input  sample_t  din_imag,
	input  twiddle_t tw_real,
	input  twiddle_t tw_imag,

	output sample_t  dout_real,
	output sample_t  dout_imag
);

	// Full product width plus one bit for the sum.
	localparam int PW = `PFA_W + `PFA_TW_W + 1;

	logic signed [PW-1:0] prod_re;
	logic signed [PW-1:0] prod_im;
	logic signed [PW-1:0] shift_re;
	logic signed [PW-1:0] shift_im;

	assign prod_re = din_real * tw_real - din_imag * tw_imag;
	assign prod_im = din_real * tw_imag + din_imag * tw_real;

	// Drop the twiddle fraction.
	assign shift_re = prod_re >>> `PFA_FRAC;
	assign shift_im = prod_im >>> `PFA_FRAC;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			dout_real <= '0;
			dout_imag <= '0;
		end
		else if (lane_val)
		begin
			dout_real <= shift_re[`PFA_W-1:0]; // Truncate to sample width.
			dout_imag <= shift_im[`PFA_W-1:0];
		end
		else
		begin
			dout_real <= '0; // Idle or masked lane.
			dout_imag <= '0;
		end
	end

endmodule

`default_nettype wire

//--- logic/pfa_params.svh
`ifndef PFA_PARAMS_SVH
`define PFA_PARAMS_SVH

// Sample and twiddle word widths.
`define PFA_W 30
`define PFA_TW_W 18
`define PFA_FRAC 16 // Twiddle scale is 2**16.

`define PFA_LANES 5 // Up to radix 5 per beat.
`define PFA_AW 8 // 256-entry twiddle table.

`endif

//--- logic/pfa_pkg.sv
`default_nettype none

`include "pfa_params.svh"

package pfa_pkg;

	typedef logic signed [`PFA_W-1:0] sample_t;
	typedef logic signed [`PFA_TW_W-1:0] twiddle_t;

	// One complex component per lane; lane index is the array index.
	typedef sample_t [`PFA_LANES-1:0] lane_vec_t;

	typedef logic [`PFA_LANES-1:0] lane_mask_t;

	// Radix of the current frame, 2 to 5.
	typedef logic [2:0] radix_t;

endpackage

`default_nettype wire

//--- logic/sig_delay.sv
`timescale 1ns/1ps
`default_nettype none

module sig_delay
	import pfa_pkg::*;
#(
	parameter type T = lane_mask_t,
	parameter int DEPTH = 1
)
(
	input  logic clk,
	input  logic rst_n,
	input  T     d,
	output T     q
);

	T stage_q [DEPTH];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < DEPTH; i++)
				stage_q[i] <= '0;
		end
		else
		begin
			stage_q[0] <= d;
			for (int i = 1; i < DEPTH; i++)
				stage_q[i] <= stage_q[i-1]; // Shift along the chain.
		end
	end

	assign q = stage_q[DEPTH-1];

endmodule

`default_nettype wire

//--- logic/twdl_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "pfa_params.svh"

module twdl_ctrl
	import pfa_pkg::*;
(
	input  logic clk,
	input  logic rst_n,

	input  radix_t     factor,
	input  logic [7:0] addr_step,
	input  logic [7:0] exp_ceil,
	input  logic [7:0] exp_time,

	input  logic in_val,

	output logic [`PFA_LANES-1:0][`PFA_AW-1:0] rd_addr,
	output lane_mask_t lane_val,
	output logic       out_val
);

	localparam int LANES = `PFA_LANES;
	localparam int AW = `PFA_AW;

	logic [7:0] exp_n; // Twiddle exponent n.
	logic [7:0] beat_cnt; // Beats spent on the current n.
	logic       hold_done;
	logic       ceil_hit;

	logic [AW-1:0] step_n;
	lane_mask_t    mask_now;
	lane_mask_t    mask_t2;

	// n is held for exp_time beats.
	assign hold_done = (beat_cnt == exp_time - 8'd1);
	assign ceil_hit = (exp_n == exp_ceil - 8'd1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			exp_n <= '0;
			beat_cnt <= '0;
		end
		else if (!in_val)
		begin
			// Idle cycle restarts the sequence.
			exp_n <= '0;
			beat_cnt <= '0;
		end
		else if (hold_done && ceil_hit)
		begin
			exp_n <= '0;
			beat_cnt <= '0;
		end
		else if (hold_done)
		begin
			exp_n <= exp_n + 8'd1;
			beat_cnt <= '0;
		end
		else
		begin
			beat_cnt <= beat_cnt + 8'd1;
		end
	end

	// Product of step and n, kept modulo the table size.
	assign step_n = AW'(addr_step * exp_n);

	for (genvar i = 0; i < LANES; i++)
	begin : g_addr
		assign rd_addr[i] = AW'(step_n * AW'(i)); // Lane 0 stays at address 0.
	end

	always_comb
	begin
		for (int i = 0; i < LANES; i++)
			mask_now[i] = in_val && (i < int'(factor));
	end

	// Mask at t+2, where the products leave the lanes.
	sig_delay #(
		.T     (lane_mask_t),
		.DEPTH (2)
	) mask_pipe_i (
		.clk   (clk),
		.rst_n (rst_n),
		.d     (mask_now),
		.q     (mask_t2)
	);

	// Lane 0 is set on every beat, so any set bit marks a beat.
	assign out_val = |mask_t2;

	// Aligned with the registered table output.
	sig_delay #(
		.T     (lane_mask_t),
		.DEPTH (1)
	) lane_val_dly_i (
		.clk   (clk),
		.rst_n (rst_n),
		.d     (mask_now),
		.q     (lane_val)
	);

endmodule

`default_nettype wire

//--- logic/twdl_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "pfa_params.svh"

module twdl_rom
	import pfa_pkg::*;
(
	input  logic              clk,
	input  logic [`PFA_AW-1:0] rd_addr,
	output twiddle_t          tw_real,
	output twiddle_t          tw_imag
);

	localparam int DEPTH = 1 << `PFA_AW;
	localparam real PI = 3.14159265358979323846;
	localparam real SCALE = real'(1 << `PFA_FRAC);

	typedef twiddle_t tw_table_t [DEPTH];

	// Entry k holds exp(-j2*pi*k/DEPTH), rounded to the nearest step.
	function automatic tw_table_t build_table(input bit neg_sin);
		tw_table_t tbl;
		real       ang;
		for (int k = 0; k < DEPTH; k++)
		begin
			ang = 2.0 * PI * real'(k) / real'(DEPTH);
			if (neg_sin)
				tbl[k] = twiddle_t'(int'(-SCALE * $sin(ang)));
			else
				tbl[k] = twiddle_t'(int'(SCALE * $cos(ang)));
		end
		return tbl;
	endfunction

	localparam tw_table_t COS_TBL = build_table(1'b0);
	localparam tw_table_t NSIN_TBL = build_table(1'b1);

	// One cycle read latency.
	always_ff @(posedge clk)
	begin
		tw_real <= COS_TBL[rd_addr];
		tw_imag <= NSIN_TBL[rd_addr];
	end

endmodule

`default_nettype wire

//--- logic/twdl_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "pfa_params.svh"

module twdl_stage
	import pfa_pkg::*;
(
	input  logic clk,
	input  logic rst_n,

	input  radix_t     factor,
	input  logic [7:0] addr_step,
	input  logic [7:0] exp_ceil,
	input  logic [7:0] exp_time,

	input  logic      in_val,
	input  lane_vec_t din_real,
	input  lane_vec_t din_imag,

	output logic      out_val,
	output lane_vec_t dout_real,
	output lane_vec_t dout_imag
);

	logic [`PFA_LANES-1:0][`PFA_AW-1:0] rd_addr;
	lane_mask_t lane_val;

	twiddle_t tw_real [`PFA_LANES];
	twiddle_t tw_imag [`PFA_LANES];

	// Samples lined up with the table outputs.
	lane_vec_t dly_real;
	lane_vec_t dly_imag;

	twdl_ctrl ctrl_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.factor    (factor),
		.addr_step (addr_step),
		.exp_ceil  (exp_ceil),
		.exp_time  (exp_time),
		.in_val    (in_val),
		.rd_addr   (rd_addr),
		.lane_val  (lane_val),
		.out_val   (out_val)
	);

	// Real and imaginary lanes ride together in one delay.
	sig_delay #(
		.T     (lane_vec_t [1:0]),
		.DEPTH (1)
	) data_dly_i (
		.clk   (clk),
		.rst_n (rst_n),
		.d     ({din_imag, din_real}),
		.q     ({dly_imag, dly_real})
	);

	for (genvar i = 0; i < `PFA_LANES; i++)
	begin : g_lane
		twdl_rom rom_i (
			.clk     (clk),
			.rd_addr (rd_addr[i]),
			.tw_real (tw_real[i]),
			.tw_imag (tw_imag[i])
		);

		cmul_lane cmul_i (
			.clk       (clk),
			.rst_n     (rst_n),
			.lane_val  (lane_val[i]),
			.din_real  (dly_real[i]),
			.din_imag  (dly_imag[i]),
			.tw_real   (tw_real[i]),
			.tw_imag   (tw_imag[i]),
			.dout_real (dout_real[i]),
			.dout_imag (dout_imag[i])
		);
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the twiddle stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module twdl_tb -o twdl_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Assertion errors are counted by the testbench instead of stopping the run.
sim_out=$(./obj_dir/twdl_sim +verilator+error+limit+100000)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1

//--- test/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen
#(
	parameter real PERIOD_NS = 8.0,
	parameter int RESET_CYCLES = 3
)
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	// Released on a falling edge, after RESET_CYCLES rising edges.
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- test/twdl_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "pfa_params.svh"

module twdl_chk
	import pfa_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input radix_t    factor,
	input logic      in_val,
	input logic      out_val,
	input lane_vec_t dout_real,
	input lane_vec_t dout_imag
);

	int fail_cnt = 0;

	// Fixed two-cycle latency.
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_val == $past(in_val, 2))
	else
	begin
		fail_cnt++;
		$error("out_val is not in_val delayed by two cycles");
	end

	a_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (!out_val && dout_real == '0 && dout_imag == '0))
	else
	begin
		fail_cnt++;
		$error("outputs are not cleared by reset");
	end

	a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!out_val |-> (dout_real == '0 && dout_imag == '0))
	else
	begin
		fail_cnt++;
		$error("a lane is nonzero while out_val is low");
	end

	// Radix of the beat that produced this output.
	for (genvar i = 1; i < `PFA_LANES; i++)
	begin : g_mask
		a_lane_off: assert property (@(posedge clk) disable iff (!rst_n)
			(i >= int'($past(factor, 2))) |-> (dout_real[i] == '0 && dout_imag[i] == '0))
		else
		begin
			fail_cnt++;
			$error("lane %0d at or above the radix is nonzero", i);
		end
	end

endmodule

`default_nettype wire

//--- test/twdl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pfa_params.svh"

module twdl_tb
	import pfa_pkg::*;
();

	localparam int N_FRAMES = 12;
	localparam int MAX_LEN = 40;
	localparam int MAX_GAP = 6;
	localparam int CUT_FRAME = 3;
	localparam int WRAP_FRAME = 5;
	localparam longint WATCHDOG_NS = longint'(N_FRAMES) * (MAX_LEN + MAX_GAP + 4) * 8;
	localparam real PI = 3.14159265358979323846;

	logic       clk;
	logic       rst_n;
	radix_t     factor;
	logic [7:0] addr_step;
	logic [7:0] exp_ceil;
	logic [7:0] exp_time;
	logic       in_val;
	lane_vec_t  din_real;
	lane_vec_t  din_imag;
	logic       out_val;
	lane_vec_t  dout_real;
	lane_vec_t  dout_imag;

	logic [31:0] rand_state = 32'hecbc;
	int n_model; // Reference exponent counters.
	int beat_model;
	int tw_cos [256];
	int tw_nsin [256];
	bit exp_val_q [$];
	lane_vec_t exp_re_q [$];
	lane_vec_t exp_im_q [$];
	int checks;
	int errors;

	clk_gen clk_gen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	twdl_stage dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.factor    (factor),
		.addr_step (addr_step),
		.exp_ceil  (exp_ceil),
		.exp_time  (exp_time),
		.in_val    (in_val),
		.din_real  (din_real),
		.din_imag  (din_imag),
		.out_val   (out_val),
		.dout_real (dout_real),
		.dout_imag (dout_imag)
	);

	bind twdl_stage twdl_chk chk_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.factor    (factor),
		.in_val    (in_val),
		.out_val   (out_val),
		.dout_real (dout_real),
		.dout_imag (dout_imag)
	);

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic int rand_below(input int n);
		return int'(next_rand() >> 8) % n;
	endfunction

	function automatic sample_t rand_sample();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		return sample_t'({hi[31:16], lo[31:18]});
	endfunction

	// Rounds x * 2**16 to the nearest integer with halves away from zero.
	function automatic int scale_round(input real x);
		real s;
		s = x * real'(1 << `PFA_FRAC);
		if (s >= 0.0)
			return $rtoi(s + 0.5);
		else
			return -$rtoi(-s + 0.5);
	endfunction

	task automatic report_value(input string name, input longint expv, input longint actv);
		errors++;
		$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expv, actv);
	endtask

	task automatic compare_outputs();
		bit        e_val;
		lane_vec_t e_re;
		lane_vec_t e_im;
		if (exp_val_q.size() >= 2)
		begin
			e_val = exp_val_q.pop_front();
			e_re = exp_re_q.pop_front();
			e_im = exp_im_q.pop_front();
			checks++;
			assert (out_val == e_val)
				else report_value("out_val", longint'(e_val), longint'(out_val));
			for (int i = 0; i < `PFA_LANES; i++)
			begin
				assert (dout_real[i] == e_re[i])
					else report_value($sformatf("dout_real[%0d]", i), e_re[i], dout_real[i]);
				assert (dout_imag[i] == e_im[i])
					else report_value($sformatf("dout_imag[%0d]", i), e_im[i], dout_imag[i]);
			end
		end
	endtask

	// Checks the output from two cycles back and drives the next input.
	task automatic drive_cycle(input bit beat);
		lane_vec_t e_re;
		lane_vec_t e_im;
		int        k;
		longint    ar;
		longint    ai;
		longint    br;
		longint    bi;
		@(negedge clk);
		compare_outputs();
		for (int i = 0; i < `PFA_LANES; i++)
		begin
			din_real[i] = rand_sample();
			din_imag[i] = rand_sample();
		end
		in_val = beat;
		e_re = '0;
		e_im = '0;
		if (beat)
		begin
			for (int i = 0; i < int'(factor); i++)
			begin
				k = (int'(addr_step) * n_model * i) % 256;
				ar = din_real[i];
				ai = din_imag[i];
				br = tw_cos[k];
				bi = tw_nsin[k];
				e_re[i] = sample_t'((ar * br - ai * bi) >>> `PFA_FRAC);
				e_im[i] = sample_t'((ar * bi + ai * br) >>> `PFA_FRAC);
			end
			beat_model++;
			if (beat_model == int'(exp_time))
			begin
				beat_model = 0;
				n_model = (n_model + 1 == int'(exp_ceil)) ? 0 : n_model + 1;
			end
		end
		else
		begin
			n_model = 0; // Idle restarts the exponent.
			beat_model = 0;
		end
		exp_val_q.push_back(beat);
		exp_re_q.push_back(e_re);
		exp_im_q.push_back(e_im);
	endtask

	initial
	begin
		int len;
		int gap;
		factor = 3'd2;
		addr_step = 8'd0;
		exp_ceil = 8'd1;
		exp_time = 8'd1;
		in_val = 1'b0;
		din_real = '0;
		din_imag = '0;
		n_model = 0;
		beat_model = 0;
		checks = 0;
		errors = 0;
		for (int k = 0; k < 256; k++)
		begin
			tw_cos[k] = scale_round($cos(2.0 * PI * real'(k) / 256.0));
			tw_nsin[k] = scale_round(-$sin(2.0 * PI * real'(k) / 256.0));
		end
		wait (rst_n === 1'b1);
		for (int f = 0; f < N_FRAMES; f++)
		begin
			factor = radix_t'(2 + rand_below(4));
			addr_step = 8'(rand_below(256));
			exp_time = 8'(1 + rand_below(4));
			exp_ceil = 8'(1 + rand_below(6));
			if (f == CUT_FRAME || f == WRAP_FRAME)
			begin
				addr_step = (f == WRAP_FRAME) ? 8'd200 : 8'd37; // 200 wraps the address.
				exp_time = 8'd1;
				exp_ceil = 8'd6;
			end
			len = 8 + rand_below(MAX_LEN - 7);
			gap = 1 + rand_below(MAX_GAP);
			for (int b = 0; b < len; b++)
			begin
				if (f == CUT_FRAME && b == 5)
					drive_cycle(1'b0); // Frame cut off, then restarted.
				drive_cycle(1'b1);
			end
			for (int g = 0; g < gap; g++)
				drive_cycle(1'b0);
		end
		repeat (2) drive_cycle(1'b0);
		$display("Compared %0d cycles: %0d scoreboard errors, %0d assertion errors",
			checks, errors, dut_i.chk_i.fail_cnt);
		if (errors == 0 && dut_i.chk_i.fail_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
